// ==== source/arrayPackage.sv ====
/*
  Shared widths, vector types and the action and error encodings of the array memory.
  Imported by every module of the design and by the testbench.
*/
package arrayPackage;

  localparam int addressBits = 4;                    // Selects one of the arrays
  localparam int indexBits   = 3;                    // Selects an element in an array
  localparam int dataBits    = 16;                   // Width of one element

  localparam int arrayCount  = 2 ** addressBits;     // Number of arrays
  localparam int arrayLength = 2 ** indexBits;       // Elements per array

  typedef logic [addressBits-1:0] arrayNumber;
  typedef logic [indexBits-1:0]   elementIndex;
  typedef logic [indexBits:0]     arraySize;         // Holds 0 to arrayLength
  typedef logic [dataBits-1:0]    dataWord;

  // Gaps in the numbering are unused codes
  typedef enum logic [7:0] {
    actionNone       = 8'd0,
    actionResetAll   = 8'd1,                         // Free every array
    actionWrite      = 8'd2,
    actionRead       = 8'd3,
    actionSize       = 8'd4,
    actionIndex      = 8'd7,                         // One plus last match
    actionLess       = 8'd8,
    actionGreater    = 8'd9,
    actionPush       = 8'd14,
    actionPop        = 8'd15,
    actionAlloc      = 8'd18,
    actionFree       = 8'd19,
    actionAdd        = 8'd20,
    actionAddAfter   = 8'd21,                        // Returns the old element
    actionSubtract   = 8'd22,
    actionSubAfter   = 8'd23,                        // Returns the old element
    actionShiftLeft  = 8'd24,
    actionShiftRight = 8'd25,
    actionNotLogical = 8'd26,
    actionBitNot     = 8'd27,
    actionBitOr      = 8'd28,
    actionBitXor     = 8'd29,
    actionBitAnd     = 8'd30
  } arrayAction;

  typedef enum logic [2:0] {
    errorNone         = 3'd0,
    errorNotAllocated = 3'd1,                        // Freed or never allocated
    errorOutOfBounds  = 3'd2,
    errorArrayFull    = 3'd3,
    errorArrayEmpty   = 3'd4,
    errorOutOfMemory  = 3'd5
  } errorCode;

endpackage

// ==== source/arrayAllocator.sv ====
/*
  Tracks which arrays are live and hands out array numbers.
  Freed numbers are reused last freed first before fresh numbers are taken in order.
*/
module arrayAllocator import arrayPackage::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       clearAll,
  input  logic       allocate,
  input  logic       free,
  input  arrayNumber array,
  output logic       arrayLive,
  output logic       canAllocate,
  output arrayNumber newArray
);

  logic [arrayCount-1:0]  live;                      // One flag per array
  arrayNumber             freedStack [arrayCount];   // Freed array numbers
  logic [addressBits:0]   stackTop;                  // Entries on the freed stack
  logic [addressBits:0]   topBelow;
  logic [addressBits:0]   freshCount;                // Next never used number
  logic                   stackEmpty;

  assign stackEmpty = stackTop == '0;
  assign topBelow   = stackTop - 1'b1;

  assign arrayLive   = live[array];
  assign canAllocate = !stackEmpty || freshCount != arrayCount;
  assign newArray    = stackEmpty ? freshCount[addressBits-1:0]
                                  : freedStack[topBelow[addressBits-1:0]];

  always_ff @(posedge clock) begin
    if (reset || clearAll) begin
      live       <= '0;
      stackTop   <= '0;
      freshCount <= '0;
    end else if (allocate) begin
      live[newArray] <= 1'b1;
      if (stackEmpty) begin
        freshCount <= freshCount + 1'b1;
      end else begin
        stackTop <= topBelow;                        // Reuse the last freed number
      end
    end else if (free) begin
      live[array] <= 1'b0;
      stackTop    <= stackTop + 1'b1;
    end
  end

  // A live array is never on the stack so a push always finds room
  always_ff @(posedge clock) begin
    if (free && !allocate) begin
      freedStack[stackTop[addressBits-1:0]] <= array;
    end
  end

endmodule

// ==== source/elementStore.sv ====
/*
  Element storage for every array, written one element per clock.
  Reads are combinational and give one addressed element and the whole addressed array.
*/
module elementStore import arrayPackage::*; (
  input  logic                         clock,
  input  logic                         writeEnable,
  input  arrayNumber                   writeArray,
  input  elementIndex                  writeIndex,
  input  dataWord                      writeData,
  input  arrayNumber                   array,
  input  elementIndex                  index,
  output dataWord                      readData,
  output dataWord [arrayLength-1:0]    arrayRow
);

  // One packed row per array, so a whole array reads out at once
  dataWord [arrayLength-1:0] memory [arrayCount];

  always_ff @(posedge clock) begin
    if (writeEnable) begin
      memory[writeArray][writeIndex] <= writeData;
    end
  end

  assign readData = memory[array][index];            // Size checks live in the controller
  assign arrayRow = memory[array];                   // Feeds the search block

endmodule

// ==== source/elementAlu.sv ====
/*
  Read-modify-write arithmetic for one element.
  Gives the value to store back for each arithmetic or logic action.
*/
module elementAlu import arrayPackage::*; (
  input  arrayAction action,
  input  dataWord    readData,
  input  dataWord    in,
  output dataWord    newValue
);

  always_comb begin
    case (action)
      actionAdd, actionAddAfter: begin
        newValue = readData + in;                    // Wraps at 16 bits
      end
      actionSubtract, actionSubAfter: begin
        newValue = readData - in;
      end
      actionShiftLeft: begin
        newValue = readData << in;                   // Amounts of 16 or more give 0
      end
      actionShiftRight: begin
        newValue = readData >> in;
      end
      actionNotLogical: begin
        newValue = dataWord'(readData == '0);
      end
      actionBitNot: begin
        newValue = ~readData;
      end
      actionBitOr: begin
        newValue = readData | in;
      end
      actionBitXor: begin
        newValue = readData ^ in;
      end
      actionBitAnd: begin
        newValue = readData & in;
      end
      default: begin
        newValue = readData;                         // Not stored for other actions
      end
    endcase
  end

endmodule

// ==== source/arraySearch.sv ====
/*
  Searches the live part of one array for a key.
  Returns one plus the last match and the counts of smaller and larger elements.
*/
module arraySearch import arrayPackage::*; (
  input  dataWord [arrayLength-1:0] arrayRow,
  input  arraySize                  currentSize,
  input  dataWord                   in,
  output dataWord                   matchPosition,
  output dataWord                   lessCount,
  output dataWord                   greaterCount
);

  always_comb begin
    matchPosition = '0;                              // Zero means no match
    lessCount     = '0;
    greaterCount  = '0;
    for (int position = 0; position < arrayLength; position++) begin
      if (arraySize'(position) < currentSize) begin
        if (arrayRow[position] == in) begin
          matchPosition = dataWord'(position + 1);   // Later matches win
        end
        if (arrayRow[position] < in) begin
          lessCount = lessCount + 1'b1;
        end
        if (arrayRow[position] > in) begin
          greaterCount = greaterCount + 1'b1;
        end
      end
    end
  end

endmodule

// ==== source/commandControl.sv ====
/*
  Command decoder of the array memory. Holds the array sizes, checks each command,
  drives the store and allocator strobes and registers out and error.
*/
module commandControl import arrayPackage::*; (
  input  logic        clock,
  input  logic        reset,
  input  arrayAction  action,
  input  arrayNumber  array,
  input  elementIndex index,
  input  dataWord     in,
  input  logic        arrayLive,
  input  logic        canAllocate,
  input  arrayNumber  newArray,
  input  dataWord     readData,
  input  dataWord     newValue,
  input  dataWord     matchPosition,
  input  dataWord     lessCount,
  input  dataWord     greaterCount,
  output logic        allocate,
  output logic        free,
  output logic        clearAll,
  output logic        writeEnable,
  output arrayNumber  writeArray,
  output elementIndex writeIndex,
  output dataWord     writeData,
  output elementIndex readIndex,
  output arraySize    currentSize,
  output dataWord     out,
  output errorCode    error
);

  arraySize   sizes [arrayCount];                    // Element count per array
  arraySize   indexSize;                             // Size implied by a write at index
  arraySize   poppedSize;
  logic       indexInside;
  logic       sizeEnable;
  arrayNumber sizeArray;
  arraySize   sizeValue;
  dataWord    nextOut;
  errorCode   nextError;

  assign currentSize = sizes[array];
  assign indexSize   = arraySize'(index) + 1'b1;
  assign poppedSize  = currentSize - 1'b1;
  assign indexInside = arraySize'(index) < currentSize;
  assign writeArray  = array;
  assign readIndex   = (action == actionPop) ? poppedSize[indexBits-1:0] : index;

  always_comb begin
    nextOut     = out;                               // Held unless a value returns
    nextError   = errorNone;
    allocate    = 1'b0;
    free        = 1'b0;
    clearAll    = 1'b0;
    writeEnable = 1'b0;
    writeIndex  = index;
    writeData   = in;
    sizeEnable  = 1'b0;
    sizeArray   = array;
    sizeValue   = currentSize;
    case (action)
      actionResetAll: clearAll = 1'b1;
      actionAlloc: begin
        if (!canAllocate) nextError = errorOutOfMemory;
        else begin
          allocate   = 1'b1;
          sizeEnable = 1'b1;
          sizeArray  = newArray;                     // New array starts empty
          sizeValue  = '0;
          nextOut    = dataWord'(newArray);
        end
      end
      actionFree: begin
        if (!arrayLive) nextError = errorNotAllocated;
        else free = 1'b1;
      end
      actionWrite: begin
        if (!arrayLive) nextError = errorNotAllocated;
        else begin
          writeEnable = 1'b1;
          sizeEnable  = 1'b1;
          sizeValue   = (indexSize > currentSize) ? indexSize : currentSize;
          nextOut     = in;
        end
      end
      actionRead: begin
        if (!arrayLive) nextError = errorNotAllocated;
        else if (!indexInside) nextError = errorOutOfBounds;
        else nextOut = readData;
      end
      actionSize: begin
        if (!arrayLive) nextError = errorNotAllocated;
        else nextOut = dataWord'(currentSize);
      end
      actionPush: begin
        if (!arrayLive) nextError = errorNotAllocated;
        else if (currentSize == arrayLength) nextError = errorArrayFull;
        else begin
          writeEnable = 1'b1;
          writeIndex  = currentSize[indexBits-1:0];  // Append after the last element
          sizeEnable  = 1'b1;
          sizeValue   = currentSize + 1'b1;
        end
      end
      actionPop: begin
        if (!arrayLive) nextError = errorNotAllocated;
        else if (currentSize == '0) nextError = errorArrayEmpty;
        else begin
          sizeEnable = 1'b1;
          sizeValue  = poppedSize;
          nextOut    = readData;                     // Read at the new size
        end
      end
      actionAdd, actionAddAfter, actionSubtract, actionSubAfter,
      actionShiftLeft, actionShiftRight, actionNotLogical,
      actionBitNot, actionBitOr, actionBitXor, actionBitAnd: begin
        if (!arrayLive) nextError = errorNotAllocated;
        else if (!indexInside) nextError = errorOutOfBounds;
        else begin
          writeEnable = 1'b1;
          writeData   = newValue;
          nextOut     = (action == actionAddAfter || action == actionSubAfter)
                        ? readData : newValue;
        end
      end
      actionIndex, actionLess, actionGreater: begin
        if (!arrayLive) nextError = errorNotAllocated;
        else if (action == actionIndex) nextOut = matchPosition;
        else if (action == actionLess) nextOut = lessCount;
        else nextOut = greaterCount;
      end
      default: ;                                     // Idle and unknown codes
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      out   <= '0;
      error <= errorNone;
      for (int n = 0; n < arrayCount; n++) begin
        sizes[n] <= '0;
      end
    end else begin
      out   <= nextOut;
      error <= nextError;
      if (sizeEnable) begin
        sizes[sizeArray] <= sizeValue;
      end
    end
  end

endmodule

// ==== source/arrayMemory.sv ====
/*
  Top level of the array memory with 16 arrays of 8 sixteen-bit elements.
  Takes one command per clock and shows the result on out and error after the edge.
*/
module arrayMemory import arrayPackage::*; (
  input  logic        clock,
  input  logic        reset,
  input  arrayAction  action,
  input  arrayNumber  array,
  input  elementIndex index,
  input  dataWord     in,
  output dataWord     out,
  output errorCode    error
);

  logic                      arrayLive;
  logic                      canAllocate;
  arrayNumber                newArray;
  logic                      allocate;
  logic                      free;
  logic                      clearAll;
  logic                      writeEnable;
  arrayNumber                writeArray;
  elementIndex               writeIndex;
  dataWord                   writeData;
  elementIndex               readIndex;                // Pop reads below the top
  arraySize                  currentSize;
  dataWord                   readData;
  dataWord [arrayLength-1:0] arrayRow;
  dataWord                   newValue;
  dataWord                   matchPosition;
  dataWord                   lessCount;
  dataWord                   greaterCount;

  commandControl control (
    .clock, .reset, .action, .array, .index, .in,
    .arrayLive, .canAllocate, .newArray,
    .readData, .newValue, .matchPosition, .lessCount, .greaterCount,
    .allocate, .free, .clearAll,
    .writeEnable, .writeArray, .writeIndex, .writeData,
    .readIndex, .currentSize, .out, .error
  );

  arrayAllocator allocator (
    .clock, .reset, .clearAll, .allocate, .free, .array,
    .arrayLive, .canAllocate, .newArray
  );

  elementStore store (
    .clock,
    .writeEnable,
    .writeArray,
    .writeIndex,
    .writeData,
    .array,
    .index    (readIndex),
    .readData,
    .arrayRow
  );

  elementAlu alu (
    .action,
    .readData,
    .in,
    .newValue
  );

  arraySearch search (
    .arrayRow,
    .currentSize,
    .in,
    .matchPosition,
    .lessCount,
    .greaterCount
  );

endmodule

// ==== sim/arrayModel.svh ====
/*
  Reference model of the array memory, included in the testbench module.
  predictCommand updates the model state and the expected out and error of one command.
*/
bit       modelLive [arrayCount];
int       modelSize [arrayCount];
dataWord  modelData [arrayCount][arrayLength];       // Contents survive free and resetAll
int       freedNumbers [$];                          // Last freed at the back
int       nextFresh;
dataWord  expectOut;
errorCode expectError;

function automatic void clearModel();
  for (int n = 0; n < arrayCount; n++) begin
    modelLive[n] = 1'b0;
  end
  freedNumbers.delete();
  nextFresh = 0;
endfunction

function automatic dataWord aluExpect(logic [7:0] code, dataWord old, dataWord operand);
  case (code)
    actionAdd, actionAddAfter:           return old + operand;
    actionSubtract, actionSubAfter:      return old - operand;
    actionShiftLeft:                     return (operand >= dataBits) ? '0 : old << operand;
    actionShiftRight:                    return (operand >= dataBits) ? '0 : old >> operand;
    actionNotLogical:                    return (old == 0) ? 16'd1 : 16'd0;
    actionBitNot:                        return ~old;
    actionBitOr:                         return old | operand;
    actionBitXor:                        return old ^ operand;
    default:                             return old & operand;
  endcase
endfunction

function automatic dataWord searchExpect(logic [7:0] code, int arr, dataWord key);
  int result;
  result = 0;
  for (int p = 0; p < modelSize[arr]; p++) begin
    if (code == actionIndex && modelData[arr][p] == key) result = p + 1;
    if (code == actionLess && modelData[arr][p] < key) result++;
    if (code == actionGreater && modelData[arr][p] > key) result++;
  end
  return dataWord'(result);
endfunction

function automatic void applyLive(logic [7:0] code, int arr, int idx, dataWord operand);
  dataWord old;
  dataWord result;
  old = modelData[arr][idx];
  case (code)
    actionFree: begin
      modelLive[arr] = 1'b0;
      freedNumbers.push_back(arr);
    end
    actionWrite: begin
      modelData[arr][idx] = operand;
      if (idx + 1 > modelSize[arr]) modelSize[arr] = idx + 1;
      expectOut = operand;
    end
    actionSize: expectOut = dataWord'(modelSize[arr]);
    actionPush: begin
      if (modelSize[arr] == arrayLength) expectError = errorArrayFull;
      else begin
        modelData[arr][modelSize[arr]] = operand;
        modelSize[arr]++;
      end
    end
    actionPop: begin
      if (modelSize[arr] == 0) expectError = errorArrayEmpty;
      else begin
        modelSize[arr]--;
        expectOut = modelData[arr][modelSize[arr]];
      end
    end
    actionIndex, actionLess, actionGreater: expectOut = searchExpect(code, arr, operand);
    default: begin                                   // Read and the arithmetic actions
      if (idx >= modelSize[arr]) expectError = errorOutOfBounds;
      else if (code == actionRead) expectOut = old;
      else begin
        result = aluExpect(code, old, operand);
        modelData[arr][idx] = result;
        expectOut = (code == actionAddAfter || code == actionSubAfter) ? old : result;
      end
    end
  endcase
endfunction

function automatic void predictCommand(logic [7:0] code, int arr, int idx, dataWord operand);
  int taken;
  expectError = errorNone;
  if (code == actionResetAll) clearModel();
  else if (code == actionAlloc) begin
    if (freedNumbers.size() == 0 && nextFresh == arrayCount) begin
      expectError = errorOutOfMemory;
    end else begin
      if (freedNumbers.size() > 0) taken = freedNumbers.pop_back();
      else begin
        taken = nextFresh;
        nextFresh = nextFresh + 1;
      end
      modelLive[taken] = 1'b1;
      modelSize[taken] = 0;
      expectOut = dataWord'(taken);
    end
  end else if ((code >= actionWrite && code <= actionSize) ||
               (code >= actionIndex && code <= actionGreater) ||
               code == actionPush || code == actionPop ||
               (code >= actionFree && code <= actionBitAnd)) begin
    if (!modelLive[arr]) expectError = errorNotAllocated;
    else applyLive(code, arr, idx, operand);
  end
endfunction

// ==== sim/arrayMemoryTest.sv ====
/*
  Testbench of the array memory. Runs a short directed start, then seeded random
  commands, and checks out and error against the included model after each command.
*/
module arrayMemoryTest import arrayPackage::*; ();
  timeunit 1ns;
  timeprecision 1ns;

  localparam int  clockPeriod  = 100;
  localparam int  resetCycles  = 10;
  localparam int  randomCount  = 3000;
  localparam int  directCount  = 200;                // Directed commands rounded up
  localparam time watchdogTime =
    (2 * (randomCount + directCount) + resetCycles + 100) * clockPeriod;

  localparam logic [7:0] keptCodes [21] = '{2, 3, 4, 7, 8, 9, 14, 15, 18, 19,
                                            20, 21, 22, 23, 24, 25, 26, 27, 28, 29, 30};
  localparam logic [7:0] oddCodes [4] = '{5, 6, 13, 99};   // Undecoded codes act as idle
  localparam logic [7:0] earlyCodes [3] = '{18, 2, 14};

  logic        clock;
  logic        reset;
  arrayAction  action;
  arrayNumber  array;
  elementIndex index;
  dataWord     in;
  dataWord     out;
  errorCode    error;

  `include "arrayModel.svh"

  arrayMemory arrayMemory_i (
    .clock, .reset, .action, .array, .index, .in, .out, .error
  );

  always #(clockPeriod / 2) clock = ~clock;

  task automatic checkData(input dataWord actual, input dataWord expected);
    if (actual !== expected) begin
      $display("Fail at %0t ns: out is %h, expected %h", $time, actual, expected);
      $display("Something failed");
      $fatal(1, "Data mismatch");
    end
  endtask

  task automatic checkError(input errorCode actual, input errorCode expected);
    if (actual !== expected) begin
      $display("Fail at %0t ns: error is %s, expected %s", $time, actual.name(),
               expected.name());
      $display("Something failed");
      $fatal(1, "Error code mismatch");
    end
  endtask

  // One command per two cycles with the result checked at the falling edge
  task automatic runCommand(input logic [7:0] code, input arrayNumber arr,
                            input elementIndex idx, input dataWord operand);
    @(posedge clock);
    action <= arrayAction'(code);
    array  <= arr;
    index  <= idx;
    in     <= operand;
    predictCommand(code, arr, idx, operand);
    @(posedge clock);
    action <= actionNone;
    @(negedge clock);
    checkError(error, expectError);
    checkData(out, expectOut);
  endtask

  function automatic dataWord fillValue(int arr, int idx);
    return dataWord'((arr * arrayLength + idx) * 40503 + 4660);
  endfunction

  function automatic logic [7:0] pickAction(int step);
    int roll;
    roll = $urandom_range(999, 0);
    if (roll < 3) return actionResetAll;             // Rare since it frees everything
    if (roll < 20) return oddCodes[$urandom_range(3, 0)];
    if (roll < 30) return actionNone;
    if (step < 400 && roll < 500) return earlyCodes[$urandom_range(2, 0)];
    return keptCodes[$urandom_range(20, 0)];
  endfunction

  function automatic dataWord pickData();
    if ($urandom_range(9, 0) < 7) return dataWord'($urandom_range(20, 0));
    return dataWord'($urandom());
  endfunction

  function automatic arrayNumber pickArray();
    if ($urandom_range(9, 0) < 8) return arrayNumber'($urandom_range(5, 0));
    return arrayNumber'($urandom_range(arrayCount - 1, 0));
  endfunction

  initial begin
    #(watchdogTime);
    $display("Watchdog expired before the last command was checked");
    $display("Something failed");
    $fatal(1, "Timeout");
  end

  initial begin
    clock  = 1'b0;
    reset  = 1'b1;
    action = actionNone;
    array  = '0;
    index  = '0;
    in     = '0;
    void'($urandom(61025));
    clearModel();
    expectOut   = '0;
    expectError = errorNone;
    repeat (resetCycles) @(posedge clock);
    reset <= 1'b0;
    runCommand(actionNone, 0, 0, 16'h1234);          // Out stays 0 after reset
    for (int a = 0; a < arrayCount; a++) begin
      runCommand(actionSize, arrayNumber'(a), 0, 16'h0);  // Nothing live yet
    end
    repeat (arrayCount + 1) runCommand(actionAlloc, 0, 0, 16'h0);  // Last is out of memory
    for (int a = 0; a < arrayCount; a++) begin
      for (int i = 0; i < arrayLength; i++) begin
        runCommand(actionWrite, arrayNumber'(a), elementIndex'(i), fillValue(a, i));
      end
    end
    runCommand(actionFree, 3, 0, 16'h0);
    runCommand(actionFree, 7, 0, 16'h0);
    runCommand(actionFree, 11, 0, 16'h0);
    repeat (3) runCommand(actionAlloc, 0, 0, 16'h0); // Expect 11, 7, 3
    runCommand(actionFree, 5, 0, 16'h0);
    runCommand(actionFree, 5, 0, 16'h0);             // Double free
    runCommand(actionResetAll, 0, 0, 16'h0);
    for (int a = 0; a < arrayCount; a++) begin
      runCommand(actionSize, arrayNumber'(a), 0, 16'h0);  // All freed again
    end
    for (int step = 0; step < randomCount; step++) begin
      runCommand(pickAction(step), pickArray(), elementIndex'($urandom_range(7, 0)),
                 pickData());
    end
    $display("Everything OK");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+sim
source/arrayPackage.sv
source/arrayAllocator.sv
source/elementStore.sv
source/elementAlu.sv
source/arraySearch.sv
source/commandControl.sv
source/arrayMemory.sv
sim/arrayMemoryTest.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing -Wno-fatal -f project.f --top-module arrayMemoryTest \
  -o arrayMemoryTest && ./obj_dir/arrayMemoryTest || exit 1
